//--- Bender.yml
package:
  name: uf_decoder

sources:
  - files:
      - common/decoder_pkg.sv
      - rtl/stage_controller.sv
      - rtl/round_counter.sv
      - grid/processing_unit.sv
      - grid/neighbor_link.sv
      - rtl/decoder_top.sv
  - target: simulation
    files:
      - testbench/tb_decoder_top.sv

//--- common/decoder_pkg.sv
package decoder_pkg;

    // grid geometry for a single measurement round
    localparam int GRID_ROWS = 4;
    localparam int GRID_COLS = 4;
    localparam int PU_COUNT = GRID_ROWS * GRID_COLS;

    localparam int ROW_WIDTH = $clog2(GRID_ROWS);
    localparam int COL_WIDTH = $clog2(GRID_COLS);
    localparam int ADDRESS_WIDTH = ROW_WIDTH + COL_WIDTH;

    // edge lengths in half-weight steps
    localparam int WEIGHT = 1;
    localparam int NEIGHBOR_COST = 2 * WEIGHT;
    localparam int BOUNDARY_COST = 2 * WEIGHT;
    localparam int GROWTH_WIDTH = 2;

    localparam int ROUND_WIDTH = 2;
    localparam int QUIET_CYCLES = 2;
    localparam int QUIET_WIDTH = $clog2(QUIET_CYCLES + 1);

    // neighbor slot of a unit, by direction
    localparam int NB_UP = 0;
    localparam int NB_DOWN = 1;
    localparam int NB_LEFT = 2;
    localparam int NB_RIGHT = 3;

    typedef enum logic [2:0] {
        STAGE_IDLE,
        STAGE_LOAD,
        STAGE_GROW,
        STAGE_MERGE,
        STAGE_REPORT
    } stage_t;

    typedef struct packed {
        logic [ROW_WIDTH-1:0] row;
        logic [COL_WIDTH-1:0] col;
    } pu_coord_t;

    // row is the upper field, so flat compare orders row-major
    typedef union packed {
        logic [ADDRESS_WIDTH-1:0] flat;
        pu_coord_t rc;
    } pu_addr_t;

endpackage

//--- filelist.f
common/decoder_pkg.sv
rtl/stage_controller.sv
rtl/round_counter.sv
grid/processing_unit.sv
grid/neighbor_link.sv
rtl/decoder_top.sv
testbench/tb_decoder_top.sv

//--- grid/neighbor_link.sv
`timescale 1ns/100ps

module neighbor_link
    import decoder_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  stage_t   stage,
    input  logic     a_occupied,
    input  logic     b_occupied,
    input  pu_addr_t a_root,
    input  pu_addr_t b_root,
    input  logic     a_touching,
    input  logic     b_touching,
    output logic     fully_grown,
    output pu_addr_t root_to_a,
    output pu_addr_t root_to_b,
    output logic     touching_to_a,
    output logic     touching_to_b
);

    logic [GROWTH_WIDTH-1:0] growth;
    logic [GROWTH_WIDTH:0]   growth_sum;

    // both ends grow into the edge at once
    assign growth_sum = {1'b0, growth} + a_occupied + b_occupied;

    always_ff @(posedge clk) begin
        if (reset) begin
            growth <= '0;
        end else if (stage == STAGE_LOAD) begin
            growth <= '0;
        end else if (stage == STAGE_GROW) begin
            if (growth_sum >= NEIGHBOR_COST) begin
                growth <= GROWTH_WIDTH'(NEIGHBOR_COST);
            end else begin
                growth <= growth_sum[GROWTH_WIDTH-1:0];
            end
        end
    end

    assign fully_grown = (growth == GROWTH_WIDTH'(NEIGHBOR_COST));

    // each side sees the far unit
    assign root_to_a = b_root;
    assign root_to_b = a_root;
    assign touching_to_a = b_touching;
    assign touching_to_b = a_touching;

endmodule

//--- grid/processing_unit.sv
`timescale 1ns/100ps

module processing_unit
    import decoder_pkg::*;
#(
    parameter int ROW = 0,
    parameter int COL = 0,
    parameter bit ON_BOUNDARY = (COL == 0) || (COL == GRID_COLS - 1)
) (
    input  logic           clk,
    input  logic           reset,
    input  stage_t         stage,
    input  logic           syndrome,
    input  logic [3:0]     neighbor_fully_grown,
    input  pu_addr_t [3:0] neighbor_roots,
    input  logic [3:0]     neighbor_touching,
    output pu_addr_t       root,
    output logic           occupied,
    output logic           touching_boundary,
    output logic           root_changed
);

    pu_addr_t                own_addr;
    pu_addr_t                merged_root;
    logic                    merged_touching;
    logic                    merged_occupied;
    logic                    syndrome_q;
    logic [GROWTH_WIDTH-1:0] boundary_growth;

    always_comb begin
        own_addr.rc.row = ROW_WIDTH'(ROW);
        own_addr.rc.col = COL_WIDTH'(COL);
    end

    // smallest root over self and fully grown links
    always_comb begin
        merged_root = root;
        merged_touching = touching_boundary | (|(neighbor_fully_grown & neighbor_touching));
        merged_occupied = occupied | (|neighbor_fully_grown);
        for (int d = 0; d < 4; d++) begin
            if (neighbor_fully_grown[d] && (neighbor_roots[d].flat < merged_root.flat)) begin
                merged_root = neighbor_roots[d];
            end
        end
    end

    // sampled every idle cycle, so the start transfer value sticks
    always_ff @(posedge clk) begin
        if (stage == STAGE_IDLE) begin
            syndrome_q <= syndrome;
        end
    end

    always_ff @(posedge clk) begin
        if (stage == STAGE_LOAD) begin
            root <= own_addr;
        end else if (stage == STAGE_MERGE) begin
            root <= merged_root;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            occupied <= 1'b0;
            touching_boundary <= 1'b0;
            boundary_growth <= '0;
            root_changed <= 1'b0;
        end else begin
            root_changed <= 1'b0;
            case (stage)
                STAGE_LOAD: begin
                    occupied <= syndrome_q;
                    touching_boundary <= 1'b0;
                    boundary_growth <= '0;
                end
                STAGE_GROW: begin
                    if (ON_BOUNDARY && occupied &&
                        (boundary_growth != GROWTH_WIDTH'(BOUNDARY_COST))) begin
                        boundary_growth <= boundary_growth + 1'b1;
                        if (boundary_growth == GROWTH_WIDTH'(BOUNDARY_COST - 1)) begin
                            touching_boundary <= 1'b1;
                        end
                    end
                end
                STAGE_MERGE: begin
                    occupied <= merged_occupied;
                    touching_boundary <= merged_touching;
                    root_changed <= (merged_root != root) ||
                                    (merged_touching != touching_boundary) ||
                                    (merged_occupied != occupied);
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- rtl/decoder_top.sv
`timescale 1ns/100ps

module decoder_top
    import decoder_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start_valid,
    output logic                   start_ready,
    input  logic [PU_COUNT-1:0]    syndromes,
    input  logic [ROUND_WIDTH-1:0] grow_rounds,
    output logic                   result_valid,
    input  logic                   result_ready,
    output pu_addr_t               roots [PU_COUNT],
    output wire  [PU_COUNT-1:0]    touching_boundary
);

    stage_t stage;
    logic   merge_done;
    logic   last_round;
    logic   has_message_flying;

    wire [PU_COUNT-1:0] occupied;
    wire [PU_COUNT-1:0] root_changed;

    // per-unit neighbor view, indexed by NB_* direction
    wire [3:0]           nb_full [PU_COUNT];
    wire pu_addr_t [3:0] nb_root [PU_COUNT];
    wire [3:0]           nb_touch [PU_COUNT];

    assign has_message_flying = |root_changed;

    stage_controller i_stage_controller (
        .clk         (clk),
        .reset       (reset),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .result_valid(result_valid),
        .result_ready(result_ready),
        .merge_done  (merge_done),
        .last_round  (last_round),
        .stage       (stage)
    );

    round_counter i_round_counter (
        .clk               (clk),
        .reset             (reset),
        .stage             (stage),
        .grow_rounds       (grow_rounds),
        .has_message_flying(has_message_flying),
        .merge_done        (merge_done),
        .last_round        (last_round)
    );

    for (genvar r = 0; r < GRID_ROWS; r++) begin : g_row
        for (genvar c = 0; c < GRID_COLS; c++) begin : g_col
            localparam int IDX = r * GRID_COLS + c;

            processing_unit #(
                .ROW(r),
                .COL(c)
            ) i_processing_unit (
                .clk                 (clk),
                .reset               (reset),
                .stage               (stage),
                .syndrome            (syndromes[IDX]),
                .neighbor_fully_grown(nb_full[IDX]),
                .neighbor_roots      (nb_root[IDX]),
                .neighbor_touching   (nb_touch[IDX]),
                .root                (roots[IDX]),
                .occupied            (occupied[IDX]),
                .touching_boundary   (touching_boundary[IDX]),
                .root_changed        (root_changed[IDX])
            );

            // grid edges have no link in that direction
            if (r == 0) begin : g_no_up
                assign nb_full[IDX][NB_UP] = 1'b0;
                assign nb_root[IDX][NB_UP] = '0;
                assign nb_touch[IDX][NB_UP] = 1'b0;
            end
            if (r == GRID_ROWS - 1) begin : g_no_down
                assign nb_full[IDX][NB_DOWN] = 1'b0;
                assign nb_root[IDX][NB_DOWN] = '0;
                assign nb_touch[IDX][NB_DOWN] = 1'b0;
            end
            if (c == 0) begin : g_no_left
                assign nb_full[IDX][NB_LEFT] = 1'b0;
                assign nb_root[IDX][NB_LEFT] = '0;
                assign nb_touch[IDX][NB_LEFT] = 1'b0;
            end
            if (c == GRID_COLS - 1) begin : g_no_right
                assign nb_full[IDX][NB_RIGHT] = 1'b0;
                assign nb_root[IDX][NB_RIGHT] = '0;
                assign nb_touch[IDX][NB_RIGHT] = 1'b0;
            end

            // a is this unit, b the unit to the right
            if (c < GRID_COLS - 1) begin : g_h_link
                wire full;

                neighbor_link i_neighbor_link (
                    .clk          (clk),
                    .reset        (reset),
                    .stage        (stage),
                    .a_occupied   (occupied[IDX]),
                    .b_occupied   (occupied[IDX+1]),
                    .a_root       (roots[IDX]),
                    .b_root       (roots[IDX+1]),
                    .a_touching   (touching_boundary[IDX]),
                    .b_touching   (touching_boundary[IDX+1]),
                    .fully_grown  (full),
                    .root_to_a    (nb_root[IDX][NB_RIGHT]),
                    .root_to_b    (nb_root[IDX+1][NB_LEFT]),
                    .touching_to_a(nb_touch[IDX][NB_RIGHT]),
                    .touching_to_b(nb_touch[IDX+1][NB_LEFT])
                );
                assign nb_full[IDX][NB_RIGHT] = full;
                assign nb_full[IDX+1][NB_LEFT] = full;
            end

            // a is this unit, b the unit below
            if (r < GRID_ROWS - 1) begin : g_v_link
                wire full;

                neighbor_link i_neighbor_link (
                    .clk          (clk),
                    .reset        (reset),
                    .stage        (stage),
                    .a_occupied   (occupied[IDX]),
                    .b_occupied   (occupied[IDX+GRID_COLS]),
                    .a_root       (roots[IDX]),
                    .b_root       (roots[IDX+GRID_COLS]),
                    .a_touching   (touching_boundary[IDX]),
                    .b_touching   (touching_boundary[IDX+GRID_COLS]),
                    .fully_grown  (full),
                    .root_to_a    (nb_root[IDX][NB_DOWN]),
                    .root_to_b    (nb_root[IDX+GRID_COLS][NB_UP]),
                    .touching_to_a(nb_touch[IDX][NB_DOWN]),
                    .touching_to_b(nb_touch[IDX+GRID_COLS][NB_UP])
                );
                assign nb_full[IDX][NB_DOWN] = full;
                assign nb_full[IDX+GRID_COLS][NB_UP] = full;
            end
        end
    end

endmodule

//--- rtl/round_counter.sv
`timescale 1ns/100ps

module round_counter
    import decoder_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  stage_t                 stage,
    input  logic [ROUND_WIDTH-1:0] grow_rounds,
    input  logic                   has_message_flying,
    output logic                   merge_done,
    output logic                   last_round
);

    logic [ROUND_WIDTH-1:0] round_target;
    logic [ROUND_WIDTH-1:0] rounds_done;
    logic [QUIET_WIDTH-1:0] quiet_count;

    // the start transfer is the last idle cycle and zero means one round
    always_ff @(posedge clk) begin
        if (stage == STAGE_IDLE) begin
            round_target <= (grow_rounds == '0) ? ROUND_WIDTH'(1) : grow_rounds;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rounds_done <= '0;
            quiet_count <= '0;
            merge_done <= 1'b0;
        end else begin
            if (stage == STAGE_LOAD) begin
                rounds_done <= '0;
            end else if (stage == STAGE_GROW) begin
                rounds_done <= rounds_done + 1'b1;
            end

            merge_done <= 1'b0;
            if ((stage != STAGE_MERGE) || has_message_flying) begin
                quiet_count <= '0;
            end else if (quiet_count != QUIET_WIDTH'(QUIET_CYCLES)) begin
                quiet_count <= quiet_count + 1'b1;
                merge_done <= (quiet_count == QUIET_WIDTH'(QUIET_CYCLES - 1));
            end
        end
    end

    assign last_round = (rounds_done == round_target);

endmodule

//--- rtl/stage_controller.sv
`timescale 1ns/100ps

module stage_controller
    import decoder_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   start_valid,
    output logic   start_ready,
    output logic   result_valid,
    input  logic   result_ready,
    input  logic   merge_done,
    input  logic   last_round,
    output stage_t stage
);

    stage_t next_stage;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= STAGE_IDLE;
        end else begin
            stage <= next_stage;
        end
    end

    always_comb begin
        next_stage = stage;
        unique case (stage)
            STAGE_IDLE: begin
                if (start_valid) begin
                    next_stage = STAGE_LOAD;
                end
            end
            STAGE_LOAD: begin
                next_stage = STAGE_GROW;
            end
            // a single grow step per round
            STAGE_GROW: begin
                next_stage = STAGE_MERGE;
            end
            STAGE_MERGE: begin
                if (merge_done) begin
                    if (last_round) begin
                        next_stage = STAGE_REPORT;
                    end else begin
                        next_stage = STAGE_GROW;
                    end
                end
            end
            // hold results until taken
            STAGE_REPORT: begin
                if (result_ready) begin
                    next_stage = STAGE_IDLE;
                end
            end
            default: begin
                next_stage = STAGE_IDLE;
            end
        endcase
    end

    assign start_ready = (stage == STAGE_IDLE);
    assign result_valid = (stage == STAGE_REPORT);

endmodule

//--- testbench/tb_decoder_top.sv
`timescale 1ns/100ps

module tb_decoder_top
    import decoder_pkg::*;
();

    localparam int RANDOM_REQUESTS = 20;
    // 200 cycles for each directed test
    localparam int TEST_COUNT = 6;
    localparam int WATCHDOG_CYCLES = 200 * TEST_COUNT;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   start_valid;
    logic                   start_ready;
    logic [PU_COUNT-1:0]    syndromes;
    logic [ROUND_WIDTH-1:0] grow_rounds;
    logic                   result_valid;
    logic                   result_ready;
    pu_addr_t               roots [PU_COUNT];
    logic [PU_COUNT-1:0]    touching_boundary;

    // expected results and model edge state
    int          exp_root [PU_COUNT];
    bit          exp_touch [PU_COUNT];
    int          right_growth [PU_COUNT];
    int          down_growth [PU_COUNT];
    logic [31:0] rng_state;

    decoder_top i_decoder_top (
        .clk              (clk),
        .reset            (reset),
        .start_valid      (start_valid),
        .start_ready      (start_ready),
        .syndromes        (syndromes),
        .grow_rounds      (grow_rounds),
        .result_valid     (result_valid),
        .result_ready     (result_ready),
        .roots            (roots),
        .touching_boundary(touching_boundary)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    // unit across a full edge in direction d or -1 when there is none
    function automatic int full_neighbor(input int i, input int d);
        int col;
        col = i % GRID_COLS;
        if (d == NB_UP && i >= GRID_COLS && down_growth[i-GRID_COLS] == NEIGHBOR_COST) begin
            return i - GRID_COLS;
        end
        if (d == NB_DOWN && i + GRID_COLS < PU_COUNT && down_growth[i] == NEIGHBOR_COST) begin
            return i + GRID_COLS;
        end
        if (d == NB_LEFT && col > 0 && right_growth[i-1] == NEIGHBOR_COST) begin
            return i - 1;
        end
        if (d == NB_RIGHT && col < GRID_COLS - 1 && right_growth[i] == NEIGHBOR_COST) begin
            return i + 1;
        end
        return -1;
    endfunction

    task automatic set_own_roots();
        for (int i = 0; i < PU_COUNT; i++) begin
            exp_root[i] = i;
            exp_touch[i] = 1'b0;
        end
    endtask

    task automatic run_model(input logic [PU_COUNT-1:0] syn, input int rounds);
        int boundary_growth [PU_COUNT];
        bit occ [PU_COUNT];
        bit changed;
        int col;
        int n;
        set_own_roots();
        for (int i = 0; i < PU_COUNT; i++) begin
            right_growth[i] = 0;
            down_growth[i] = 0;
            boundary_growth[i] = 0;
            occ[i] = syn[i];
        end
        if (rounds == 0) begin
            rounds = 1;
        end
        for (int r = 0; r < rounds; r++) begin
            for (int i = 0; i < PU_COUNT; i++) begin
                col = i % GRID_COLS;
                if (col < GRID_COLS - 1) begin
                    right_growth[i] = right_growth[i] + occ[i] + occ[i+1];
                    if (right_growth[i] > NEIGHBOR_COST) begin
                        right_growth[i] = NEIGHBOR_COST;
                    end
                end
                if (i + GRID_COLS < PU_COUNT) begin
                    down_growth[i] = down_growth[i] + occ[i] + occ[i+GRID_COLS];
                    if (down_growth[i] > NEIGHBOR_COST) begin
                        down_growth[i] = NEIGHBOR_COST;
                    end
                end
                if (occ[i] && (col == 0 || col == GRID_COLS - 1) &&
                    boundary_growth[i] < BOUNDARY_COST) begin
                    boundary_growth[i]++;
                    if (boundary_growth[i] == BOUNDARY_COST) begin
                        exp_touch[i] = 1'b1;
                    end
                end
            end
            // spread roots and flags until settled
            do begin
                changed = 1'b0;
                for (int i = 0; i < PU_COUNT; i++) begin
                    for (int d = 0; d < 4; d++) begin
                        n = full_neighbor(i, d);
                        if (n >= 0) begin
                            occ[i] = 1'b1;
                            if (exp_root[n] < exp_root[i]) begin
                                exp_root[i] = exp_root[n];
                                changed = 1'b1;
                            end
                            if (exp_touch[n] && !exp_touch[i]) begin
                                exp_touch[i] = 1'b1;
                                changed = 1'b1;
                            end
                        end
                    end
                end
            end while (changed);
        end
    endtask

    task automatic send_request(input logic [PU_COUNT-1:0] syn,
                                input logic [ROUND_WIDTH-1:0] rounds);
        bit ready_seen;
        @(posedge clk);
        start_valid <= 1'b1;
        syndromes <= syn;
        grow_rounds <= rounds;
        do begin
            @(negedge clk);
            ready_seen = start_ready;
            @(posedge clk);
        end while (!ready_seen);
        start_valid <= 1'b0;
        // request fields only count on the transfer edge
        syndromes <= ~syn;
        grow_rounds <= ~rounds;
    endtask

    task automatic wait_result();
        do @(negedge clk); while (!result_valid);
    endtask

    task automatic take_result();
        @(posedge clk);
        result_ready <= 1'b1;
        @(posedge clk);
        result_ready <= 1'b0;
    endtask

    task automatic check_result(input string tag);
        for (int i = 0; i < PU_COUNT; i++) begin
            assert (roots[i].flat == exp_root[i]) else
                report_error($sformatf("%s: unit %0d root %0d, expected %0d",
                                       tag, i, roots[i].flat, exp_root[i]));
            assert (touching_boundary[i] == exp_touch[i]) else
                report_error($sformatf("%s: unit %0d touching %b, expected %b",
                                       tag, i, touching_boundary[i], exp_touch[i]));
        end
    endtask

    task automatic test_reset_handshake();
        @(negedge clk);
        assert (start_ready === 1'b1) else report_error("start_ready low after reset");
        assert (result_valid === 1'b0) else report_error("result_valid high after reset");
        send_request('0, 2'd1);
        @(negedge clk);
        assert (start_ready === 1'b0) else report_error("start_ready high after start");
        wait_result();
        take_result();
    endtask

    task automatic test_empty_grid();
        for (int r = 0; r < 4; r++) begin
            send_request('0, ROUND_WIDTH'(r));
            wait_result();
            set_own_roots();
            check_result($sformatf("empty grid, %0d rounds", r));
            take_result();
        end
    endtask

    task automatic test_horizontal_pair();
        // units 5 and 6 sit in row 1, columns 1 and 2
        send_request(16'h0060, 2'd1);
        wait_result();
        set_own_roots();
        exp_root[6] = 5;
        check_result("horizontal pair");
        take_result();
    endtask

    task automatic test_edge_defect();
        // defect at row 1 of the first column reaches 0, 5 and 8
        send_request(16'h0010, 2'd2);
        wait_result();
        set_own_roots();
        exp_root[4] = 0;
        exp_root[5] = 0;
        exp_root[8] = 0;
        exp_touch[0] = 1'b1;
        exp_touch[4] = 1'b1;
        exp_touch[5] = 1'b1;
        exp_touch[8] = 1'b1;
        check_result("edge defect");
        take_result();
    endtask

    task automatic test_random();
        logic [ROUND_WIDTH-1:0] rounds;
        for (int k = 0; k < RANDOM_REQUESTS; k++) begin
            rng_state = xorshift(rng_state);
            rounds = ROUND_WIDTH'((rng_state[31:16] % 3) + 1);
            send_request(rng_state[PU_COUNT-1:0], rounds);
            run_model(rng_state[PU_COUNT-1:0], rounds);
            wait_result();
            check_result($sformatf("random %0d", k));
            take_result();
        end
    endtask

    task automatic test_back_pressure();
        pu_addr_t            held_roots [PU_COUNT];
        logic [PU_COUNT-1:0] held_touch;
        send_request(16'h8421, 2'd2);
        run_model(16'h8421, 2);
        wait_result();
        check_result("back pressure");
        held_roots = roots;
        held_touch = touching_boundary;
        repeat (10) begin
            @(negedge clk);
            assert (result_valid === 1'b1) else report_error("result_valid dropped while held");
            assert (start_ready === 1'b0) else report_error("start_ready high while held");
            assert (touching_boundary === held_touch) else
                report_error("touching_boundary changed while held");
            for (int i = 0; i < PU_COUNT; i++) begin
                assert (roots[i] === held_roots[i]) else
                    report_error($sformatf("unit %0d root changed while held", i));
            end
        end
        take_result();
        @(negedge clk);
        assert (start_ready === 1'b1) else report_error("start_ready low after result taken");
        send_request(16'h0660, 2'd3);
        run_model(16'h0660, 3);
        wait_result();
        check_result("request after back pressure");
        take_result();
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset = 1'b1;
        start_valid = 1'b0;
        syndromes = '0;
        grow_rounds = '0;
        result_ready = 1'b0;
        rng_state = 32'h707b64a5;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        test_reset_handshake();
        test_empty_grid();
        test_horizontal_pair();
        test_edge_defect();
        test_random();
        test_back_pressure();
        $display("Simulation passed");
        $finish;
    end

endmodule
